// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2c_master_write
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP BUILD_DIR FILELIST VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/i2c_master_write_checker.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master_write_checker (
    input wire logic              clk_50m,
    input wire logic              rst_n,
    input wire logic              scl_o,
    input wire logic              sda_o,
    input wire logic              sda_oe_o,
    input wire logic              busy_o,
    input wire logic              done_o,
    input wire i2c_pkg::sda_sel_e sda_sel
);
    import i2c_pkg::*;

    // with SCL high, SDA may only move for START and STOP, never the enable
    property sda_moves_on_low_scl;
        @(posedge clk_50m) disable iff (!rst_n)
            (($changed(sda_o) || $changed(sda_oe_o)) && scl_o)
                |-> (busy_o && $stable(sda_oe_o)
                     && (($past(sda_sel) == SEL_LOW) || ($past(sda_sel) == SEL_HIGH)));
    endproperty

    property done_single_cycle;
        @(posedge clk_50m) disable iff (!rst_n)
            done_o |=> !done_o;
    endproperty

    property scl_high_when_idle;
        @(posedge clk_50m) disable iff (!rst_n)
            !busy_o |-> scl_o;
    endproperty

    assert property (sda_moves_on_low_scl)
        else $error("SDA changed while SCL was high outside START or STOP");
    assert property (done_single_cycle)
        else $error("done_o stayed high for more than one cycle");
    assert property (scl_high_when_idle)
        else $error("SCL low while the master is not busy");

endmodule

bind i2c_master_write i2c_master_write_checker checker_inst (
    .clk_50m  (clk_50m),
    .rst_n    (rst_n),
    .scl_o    (scl_o),
    .sda_o    (sda_o),
    .sda_oe_o (sda_oe_o),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .sda_sel  (sda_sel)
);

`default_nettype wire

// File: bench/tb_i2c_master_write.sv
`timescale 1ns/10ps
`default_nettype none

module tb_i2c_master_write;
    import i2c_pkg::*;

    localparam int NUM_ROWS = 8;
    localparam int WAIT_LIMIT = 2000;  // cycles, far above one 40 tick frame

    logic  clk_50m = 1'b0;
    logic  rst_n = 1'b0;
    logic  wr_en_i = 1'b0;
    byte_t addr_i = '0;
    byte_t data_i = '0;
    wire   sda_i;
    logic  scl_o;
    logic  sda_o;
    logic  sda_oe_o;
    logic  busy_o;
    logic  done_o;
    logic  ack_addr_o;
    logic  ack_data_o;

    // open-drain bus with pull-up, slave can only pull low
    logic  slave_pull = 1'b0;
    wire   sda_bus = (sda_oe_o ? sda_o : 1'b1) & !slave_pull;
    assign sda_i = sda_bus;

    byte_t       addr_tbl [NUM_ROWS];
    byte_t       data_tbl [NUM_ROWS];
    logic        ack_a_tbl [NUM_ROWS];
    logic        ack_d_tbl [NUM_ROWS];
    logic        want_ack_addr = 1'b0;
    logic        want_ack_data = 1'b0;
    logic [31:0] lfsr_state = 32'h3f8a_c90b;
    logic [31:0] bit_buf;
    int          rise_cnt = 0;
    int          start_cnt = 0;
    int          stop_cnt = 0;
    int          done_cnt = 0;

    always #10 clk_50m = !clk_50m;

    i2c_master_write #(
        .SCL_DIV (4)
    ) i2c_master_write_inst (
        .clk_50m    (clk_50m),
        .rst_n      (rst_n),
        .wr_en_i    (wr_en_i),
        .addr_i     (addr_i),
        .data_i     (data_i),
        .sda_i      (sda_i),
        .scl_o      (scl_o),
        .sda_o      (sda_o),
        .sda_oe_o   (sda_oe_o),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .ack_addr_o (ack_addr_o),
        .ack_data_o (ack_data_o)
    );

    // bus decoder
    always @(negedge sda_bus) begin
        if (rst_n && scl_o === 1'b1) begin
            start_cnt = start_cnt + 1;
            rise_cnt  = 0;
            bit_buf   = '0;
        end
    end

    always @(posedge sda_bus) begin
        if (rst_n && scl_o === 1'b1) stop_cnt = stop_cnt + 1;
    end

    always @(posedge scl_o) begin
        if (rst_n) begin
            if (rise_cnt < 32) bit_buf[31 - rise_cnt] = sda_bus;  // first bit at the top
            rise_cnt = rise_cnt + 1;
        end
    end

    // slave pulls SDA in the ninth clock of each byte
    always @(negedge scl_o) begin
        if (rise_cnt == 8) slave_pull = want_ack_addr;
        else if (rise_cnt == 17) slave_pull = want_ack_data;
        else slave_pull = 1'b0;
    end

    always @(posedge clk_50m) begin
        if (done_o) done_cnt = done_cnt + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp_v, act_v);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        while (!busy_o) begin
            @(posedge clk_50m);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout: the master never became busy");
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do begin
            @(posedge clk_50m);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout: no done pulse at the end of the transfer");
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end while (!done_o);
    endtask

    task automatic run_row(input int r);
        logic [7:0] got_addr;
        logic [7:0] got_data;
        want_ack_addr = ack_a_tbl[r];
        want_ack_data = ack_d_tbl[r];
        start_cnt = 0;
        stop_cnt  = 0;
        done_cnt  = 0;
        @(posedge clk_50m);
        wr_en_i <= 1'b1;
        addr_i  <= addr_tbl[r];
        data_i  <= data_tbl[r];
        @(posedge clk_50m);
        wr_en_i <= 1'b0;
        wait_busy();
        check_value("ack_addr cleared", 0, ack_addr_o);
        check_value("ack_data cleared", 0, ack_data_o);
        repeat (50) @(posedge clk_50m);
        wr_en_i <= 1'b1;  // ignored while busy
        addr_i  <= ~addr_tbl[r];
        data_i  <= ~data_tbl[r];
        @(posedge clk_50m);
        wr_en_i <= 1'b0;
        wait_done();
        check_value("ack_addr", ack_a_tbl[r], ack_addr_o);
        check_value("ack_data", ack_d_tbl[r], ack_data_o);
        repeat (10) begin
            @(posedge clk_50m);
            check_value("no restart", 0, busy_o);
            check_value("ack_addr held", ack_a_tbl[r], ack_addr_o);
            check_value("ack_data held", ack_d_tbl[r], ack_data_o);
        end
        got_addr = bit_buf[31:24];
        got_data = bit_buf[22:15];
        check_value("addr byte", addr_tbl[r], got_addr);
        check_value("addr ack slot", !ack_a_tbl[r], bit_buf[23]);
        check_value("data byte", data_tbl[r], got_data);
        check_value("data ack slot", !ack_d_tbl[r], bit_buf[14]);
        // 9 clocks per byte plus the STOP setup clock
        check_value("scl rises", 19, rise_cnt);
        check_value("start count", 1, start_cnt);
        check_value("stop count", 1, stop_cnt);
        check_value("done pulses", 1, done_cnt);
    endtask

    initial begin
        addr_tbl[0]  = 8'hA0;
        data_tbl[0]  = 8'h5A;
        ack_a_tbl[0] = 1;
        ack_d_tbl[0] = 1;
        addr_tbl[1]  = 8'hFF;
        data_tbl[1]  = 8'h00;
        ack_a_tbl[1] = 0;
        ack_d_tbl[1] = 1;
        addr_tbl[2]  = 8'h01;
        data_tbl[2]  = 8'h80;
        ack_a_tbl[2] = 1;
        ack_d_tbl[2] = 0;
        addr_tbl[3]  = 8'h3C;
        data_tbl[3]  = 8'hC3;
        ack_a_tbl[3] = 0;
        ack_d_tbl[3] = 0;
        for (int r = 4; r < NUM_ROWS; r++) begin
            logic [7:0] v;
            rand_bits(8, v);
            addr_tbl[r] = v;
            rand_bits(8, v);
            data_tbl[r] = v;
            rand_bits(1, v);
            ack_a_tbl[r] = v[0];
            rand_bits(1, v);
            ack_d_tbl[r] = v[0];
        end
        repeat (5) @(posedge clk_50m);
        rst_n <= 1'b1;
        @(posedge clk_50m);
        @(posedge clk_50m);
        check_value("reset scl", 1, scl_o);
        check_value("reset sda", 1, sda_o);
        check_value("reset sda_oe", 1, sda_oe_o);
        check_value("reset busy", 0, busy_o);
        check_value("reset done", 0, done_o);
        check_value("reset ack_addr", 0, ack_addr_o);
        check_value("reset ack_data", 0, ack_data_o);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/i2c_byte_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_shifter (
    input  logic           clk_50m,
    input  logic           rst_n,
    input  logic           load_i,
    input  logic           shift_i,
    input  i2c_pkg::byte_t byte_i,
    output logic           msb_o
);
    import i2c_pkg::*;

    byte_t byte_q;

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            byte_q <= '0;
        end else if (load_i) begin
            byte_q <= byte_i;  // load wins over shift
        end else if (shift_i) begin
            byte_q <= {byte_q[BYTE_W-2:0], 1'b0};
        end
    end

    assign msb_o = byte_q[BYTE_W-1];  // bit currently on the bus

endmodule

`default_nettype wire

// File: design/i2c_master_write.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master_write #(
    parameter int unsigned SCL_DIV = i2c_pkg::SCL_DIV_DEFAULT  // 2 to 255
) (
    input  logic           clk_50m,
    input  logic           rst_n,
    input  logic           wr_en_i,
    input  i2c_pkg::byte_t addr_i,   // includes the r/w bit
    input  i2c_pkg::byte_t data_i,
    input  logic           sda_i,
    output logic           scl_o,
    output logic           sda_o,
    output logic           sda_oe_o,
    output logic           busy_o,
    output logic           done_o,
    output logic           ack_addr_o,
    output logic           ack_data_o
);
    import i2c_pkg::*;

    sda_sel_e sda_sel;
    logic     addr_load;
    logic     addr_shift;
    logic     data_load;
    logic     data_shift;
    logic     addr_bit;
    logic     data_bit;

    i2c_scl_if scl_if ();

    i2c_scl_timer #(
        .SCL_DIV (SCL_DIV)
    ) scl_timer (
        .clk_50m (clk_50m),
        .rst_n   (rst_n),
        .scl     (scl_if.timer)
    );

    i2c_write_fsm write_fsm (
        .clk_50m      (clk_50m),
        .rst_n        (rst_n),
        .wr_en_i      (wr_en_i),
        .sda_i        (sda_i),
        .scl          (scl_if.seq),
        .addr_load_o  (addr_load),
        .addr_shift_o (addr_shift),
        .data_load_o  (data_load),
        .data_shift_o (data_shift),
        .sda_sel_o    (sda_sel),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .ack_addr_o   (ack_addr_o),
        .ack_data_o   (ack_data_o)
    );

    i2c_byte_shifter addr_shifter (
        .clk_50m (clk_50m),
        .rst_n   (rst_n),
        .load_i  (addr_load),  // captures addr_i on acceptance
        .shift_i (addr_shift),
        .byte_i  (addr_i),
        .msb_o   (addr_bit)
    );

    i2c_byte_shifter data_shifter (
        .clk_50m (clk_50m),
        .rst_n   (rst_n),
        .load_i  (data_load),
        .shift_i (data_shift),
        .byte_i  (data_i),
        .msb_o   (data_bit)
    );

    i2c_sda_driver sda_driver (
        .clk_50m    (clk_50m),
        .rst_n      (rst_n),
        .sel_i      (sda_sel),
        .addr_bit_i (addr_bit),
        .data_bit_i (data_bit),
        .sda_o      (sda_o),
        .sda_oe_o   (sda_oe_o)
    );

    assign scl_o = scl_if.scl;  // already registered in the timer

endmodule

`default_nettype wire

// File: design/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    localparam int BYTE_W = 8;
    typedef logic [BYTE_W-1:0] byte_t;

    localparam int FRAME_BITS = BYTE_W + 1;       // eight data bits plus the ack slot
    typedef logic [3:0] bit_cnt_t;                // 0 to FRAME_BITS-1

    localparam int unsigned SCL_DIV_DEFAULT = 4;  // clk_50m cycles per SCL half period
    typedef logic [7:0] div_t;

    // one-hot sequencer state, the spare code falls back to IDLE
    typedef enum logic [10:0] {
        IDLE      = 11'b000_0000_0001,
        START     = 11'b000_0000_0010,
        ADDR      = 11'b000_0000_0100,
        ACK_ADDR  = 11'b000_0000_1000,
        DATA      = 11'b000_0001_0000,
        ACK_DATA  = 11'b000_0010_0000,
        STOP_LOW  = 11'b000_0100_0000,
        STOP_HIGH = 11'b000_1000_0000,
        STOP_RISE = 11'b001_0000_0000,
        DONE      = 11'b010_0000_0000,
        SPARE     = 11'b100_0000_0000
    } fsm_state_e;

    typedef enum logic [2:0] {
        SEL_HIGH    = 3'd0,
        SEL_LOW     = 3'd1,
        SEL_ADDR    = 3'd2,
        SEL_DATA    = 3'd3,
        SEL_RELEASE = 3'd4   // ack slot, slave owns SDA
    } sda_sel_e;

endpackage

`default_nettype wire

// File: design/i2c_scl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface i2c_scl_if;
    import i2c_pkg::*;

    logic     run;      // divider enable
    logic     scl_en;   // SCL toggles on tick while set
    logic     tick;     // one cycle per SCL half period
    logic     scl;      // current SCL level
    bit_cnt_t bit_cnt;  // falling edges seen in the current byte

    modport timer (
        input  run,
        input  scl_en,
        output tick,
        output scl,
        output bit_cnt
    );

    modport seq (
        output run,
        output scl_en,
        input  tick,
        input  scl,
        input  bit_cnt
    );

endinterface

`default_nettype wire

// File: design/i2c_scl_timer.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_scl_timer #(
    parameter int unsigned SCL_DIV = i2c_pkg::SCL_DIV_DEFAULT
) (
    input  logic     clk_50m,
    input  logic     rst_n,
    i2c_scl_if.timer scl
);
    import i2c_pkg::*;

    localparam div_t     DIV_LAST = div_t'(SCL_DIV - 1);
    localparam bit_cnt_t CNT_LAST = bit_cnt_t'(FRAME_BITS - 1);

    div_t     div_q;
    logic     tick;
    logic     scl_q;
    bit_cnt_t bit_cnt_q;

    // tick marks the cycle whose closing edge moves SCL
    assign tick = scl.run && (div_q == DIV_LAST);

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            div_q <= '0;
        end else if (!scl.run || tick) begin
            div_q <= '0;  // restart the half period
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            scl_q     <= 1'b1;
            bit_cnt_q <= '0;
        end else if (!scl.scl_en) begin
            scl_q     <= 1'b1;  // bus idle or stop, SCL parked high
            bit_cnt_q <= '0;
        end else if (tick) begin
            scl_q <= !scl_q;
            if (scl_q) begin
                // falling edge, count it and wrap at the end of the frame
                if (bit_cnt_q == CNT_LAST) begin
                    bit_cnt_q <= '0;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end
        end
    end

    assign scl.tick    = tick;
    assign scl.scl     = scl_q;
    assign scl.bit_cnt = bit_cnt_q;

endmodule

`default_nettype wire

// File: design/i2c_sda_driver.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_sda_driver (
    input  logic              clk_50m,
    input  logic              rst_n,
    input  i2c_pkg::sda_sel_e sel_i,
    input  logic              addr_bit_i,
    input  logic              data_bit_i,
    output logic              sda_o,
    output logic              sda_oe_o
);
    import i2c_pkg::*;

    logic sda_d;
    logic oe_d;

    always_comb begin
        sda_d = 1'b1;
        oe_d  = 1'b1;
        case (sel_i)
            SEL_HIGH: begin
                sda_d = 1'b1;  // idle level, also the stop edge
            end
            SEL_LOW: begin
                sda_d = 1'b0;  // start condition and stop setup
            end
            SEL_ADDR: begin
                sda_d = addr_bit_i;
            end
            SEL_DATA: begin
                sda_d = data_bit_i;
            end
            SEL_RELEASE: begin
                oe_d = 1'b0;  // let the slave drive the ack
            end
            default: begin
                sda_d = 1'b1;
                oe_d  = 1'b1;
            end
        endcase
    end

    // single output register so the pads never see a decode glitch
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            sda_o    <= 1'b1;
            sda_oe_o <= 1'b1;
        end else begin
            sda_o    <= sda_d;
            sda_oe_o <= oe_d;
        end
    end

endmodule

`default_nettype wire

// File: design/i2c_write_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_write_fsm (
    input  logic              clk_50m,
    input  logic              rst_n,
    input  logic              wr_en_i,
    input  logic              sda_i,
    i2c_scl_if.seq            scl,
    output logic              addr_load_o,
    output logic              addr_shift_o,
    output logic              data_load_o,
    output logic              data_shift_o,
    output i2c_pkg::sda_sel_e sda_sel_o,
    output logic              busy_o,
    output logic              done_o,
    output logic              ack_addr_o,
    output logic              ack_data_o
);
    import i2c_pkg::*;

    fsm_state_e state_q;
    fsm_state_e state_d;
    logic       accept;
    logic       rise_tick;
    logic       fall_tick;
    logic       last_bit;
    logic       ack_addr_q;
    logic       ack_data_q;

    assign accept    = (state_q == IDLE) && wr_en_i;
    assign rise_tick = scl.tick && !scl.scl;  // SCL goes high after this cycle
    assign fall_tick = scl.tick && scl.scl;   // SCL goes low after this cycle
    assign last_bit  = (scl.bit_cnt == bit_cnt_t'(FRAME_BITS - 1));

    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (accept) state_d = START;
            START:     if (scl.tick) state_d = ADDR;   // SCL falls after start hold
            ADDR:      if (fall_tick && last_bit) state_d = ACK_ADDR;
            ACK_ADDR:  if (fall_tick) state_d = DATA;  // sent even after a nack
            DATA:      if (fall_tick && last_bit) state_d = ACK_DATA;
            ACK_DATA:  if (fall_tick) state_d = STOP_LOW;
            STOP_LOW:  if (scl.tick) state_d = STOP_HIGH;
            STOP_HIGH: if (scl.tick) state_d = STOP_RISE;
            STOP_RISE: if (scl.tick) state_d = DONE;
            DONE:      state_d = IDLE;
            SPARE:     state_d = IDLE;
            default:   state_d = IDLE;                 // illegal one-hot codes
        endcase
    end

    always_comb begin
        scl.run      = 1'b1;
        scl.scl_en   = 1'b1;
        sda_sel_o    = SEL_HIGH;
        addr_shift_o = 1'b0;
        data_shift_o = 1'b0;
        busy_o       = 1'b1;
        done_o       = 1'b0;
        case (state_q)
            START: begin
                sda_sel_o = SEL_LOW;
            end
            ADDR: begin
                sda_sel_o    = SEL_ADDR;
                addr_shift_o = fall_tick;  // next bit appears while SCL is low
            end
            ACK_ADDR: begin
                sda_sel_o = SEL_RELEASE;
            end
            DATA: begin
                sda_sel_o    = SEL_DATA;
                data_shift_o = fall_tick;
            end
            ACK_DATA: begin
                sda_sel_o = SEL_RELEASE;
            end
            STOP_LOW: begin
                sda_sel_o = SEL_LOW;  // pull SDA down under low SCL
            end
            STOP_HIGH: begin
                scl.scl_en = 1'b0;  // SCL back high, SDA still low
                sda_sel_o  = SEL_LOW;
            end
            STOP_RISE: begin
                scl.scl_en = 1'b0;  // SDA rises with SCL high
            end
            DONE: begin
                scl.run    = 1'b0;
                scl.scl_en = 1'b0;
                busy_o     = 1'b0;
                done_o     = 1'b1;
            end
            default: begin
                scl.run    = 1'b0;  // IDLE and the spare code
                scl.scl_en = 1'b0;
                busy_o     = 1'b0;
            end
        endcase
    end

    // ack is an active low response, held until the next transfer starts
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            ack_addr_q <= 1'b0;
            ack_data_q <= 1'b0;
        end else if (accept) begin
            ack_addr_q <= 1'b0;
            ack_data_q <= 1'b0;
        end else begin
            if ((state_q == ACK_ADDR) && rise_tick) begin
                ack_addr_q <= !sda_i;
            end
            if ((state_q == ACK_DATA) && rise_tick) begin
                ack_data_q <= !sda_i;
            end
        end
    end

    assign addr_load_o = accept;
    assign data_load_o = accept;
    assign ack_addr_o  = ack_addr_q;
    assign ack_data_o  = ack_data_q;

endmodule

`default_nettype wire

// File: src.f
design/i2c_pkg.sv
design/i2c_scl_if.sv
design/i2c_scl_timer.sv
design/i2c_byte_shifter.sv
design/i2c_sda_driver.sv
design/i2c_write_fsm.sv
design/i2c_master_write.sv
bench/i2c_master_write_checker.sv
bench/tb_i2c_master_write.sv
